// ==== include/intm_settings.svh ====
`ifndef INTM_SETTINGS_SVH
`define INTM_SETTINGS_SVH

// datapath width
`define INTM_XLEN        32

// physical register file
`define INTM_PHYS_REGS   32
`define INTM_PRF_IDX     5

// reorder buffer id width
`define INTM_ROB_IDX     4

// reservation station size
`define INTM_RS_DEPTH    4
`define INTM_RS_IDX      2

// cdb lanes, 0 = local md unit, 1 = external units
`define INTM_CDB_WIDTH   2

`endif

// ==== hw/intm_pkg.sv ====
`include "intm_settings.svh"

package intm_pkg;

    // md unit opcodes, all unsigned
    typedef enum logic [1:0] {
        MD_MUL   = 2'd0,
        MD_MULHU = 2'd1,
        MD_DIVU  = 2'd2,
        MD_REMU  = 2'd3
    } md_op_e;

    // control fsm states
    typedef enum logic [1:0] {
        MD_IDLE = 2'd0,
        MD_BUSY = 2'd1,
        MD_DONE = 2'd2
    } md_state_e;

    // one station entry, as dispatched
    typedef struct packed {
        logic [`INTM_ROB_IDX-1:0] rob_id;
        logic [`INTM_PRF_IDX-1:0] rd_phy;
        logic [`INTM_PRF_IDX-1:0] rs1_phy;
        logic [`INTM_PRF_IDX-1:0] rs2_phy;
        logic                     rs1_valid;
        logic                     rs2_valid;
        md_op_e                   op;
    } intm_uop_t;

    // issue payload, operands already read
    typedef struct packed {
        logic [`INTM_ROB_IDX-1:0] rob_id;
        logic [`INTM_PRF_IDX-1:0] rd_phy;
        md_op_e                   op;
        logic [`INTM_XLEN-1:0]    rs1_value;
        logic [`INTM_XLEN-1:0]    rs2_value;
    } intm_issue_t;

endpackage

// ==== hw/intm_itf.sv ====
`timescale 1ns/1ps
`include "intm_settings.svh"

// --------------------------------------------------
// result broadcast lane
// --------------------------------------------------
interface cdb_itf;

    logic                     valid;
    logic [`INTM_ROB_IDX-1:0] rob_id;
    logic [`INTM_PRF_IDX-1:0] rd_phy;
    logic [`INTM_XLEN-1:0]    value;

    // producer of the lane
    modport src (
        output valid, rob_id, rd_phy, value
    );

    // regfile and station listen
    modport snoop (
        input valid, rob_id, rd_phy, value
    );

endinterface

// --------------------------------------------------
// station to regfile operand read
// --------------------------------------------------
interface rs_prf_itf;

    logic [`INTM_PRF_IDX-1:0] rs1_phy;
    logic [`INTM_PRF_IDX-1:0] rs2_phy;
    logic [`INTM_XLEN-1:0]    rs1_value;
    logic [`INTM_XLEN-1:0]    rs2_value;

    // station sends tags
    modport rs (
        output rs1_phy, rs2_phy,
        input  rs1_value, rs2_value
    );

    // regfile answers combinationally
    modport prf (
        input  rs1_phy, rs2_phy,
        output rs1_value, rs2_value
    );

endinterface

// ==== hw/phys_regfile.sv ====
`timescale 1ns/1ps
`include "intm_settings.svh"

module phys_regfile (
    input  logic  clk,
    input  logic  rst,
    cdb_itf.snoop cdb [`INTM_CDB_WIDTH],
    rs_prf_itf.prf prf
);

    // flattened lane view, interface arrays need constant indices
    logic                     lane_valid [`INTM_CDB_WIDTH];
    logic [`INTM_PRF_IDX-1:0] lane_tag   [`INTM_CDB_WIDTH];
    logic [`INTM_XLEN-1:0]    lane_value [`INTM_CDB_WIDTH];

    for (genvar k = 0; k < `INTM_CDB_WIDTH; k++) begin : g_lane
        assign lane_valid[k] = cdb[k].valid;
        assign lane_tag[k]   = cdb[k].rd_phy;
        assign lane_value[k] = cdb[k].value;
    end

    logic [`INTM_XLEN-1:0] regs [`INTM_PHYS_REGS];

    // write from every valid lane, higher lane last
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `INTM_PHYS_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int k = 0; k < `INTM_CDB_WIDTH; k++) begin
                if (lane_valid[k]) begin
                    regs[lane_tag[k]] <= lane_value[k];
                end
            end
        end
    end

    // read ports, same-cycle broadcast overrides stored value
    always_comb begin
        prf.rs1_value = regs[prf.rs1_phy];
        prf.rs2_value = regs[prf.rs2_phy];
        for (int k = 0; k < `INTM_CDB_WIDTH; k++) begin
            if (lane_valid[k] && lane_tag[k] == prf.rs1_phy) begin
                prf.rs1_value = lane_value[k];
            end
            if (lane_valid[k] && lane_tag[k] == prf.rs2_phy) begin
                prf.rs2_value = lane_value[k];
            end
        end
    end

endmodule

// ==== hw/intm_rs.sv ====
`timescale 1ns/1ps
`include "intm_settings.svh"

module intm_rs (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  disp_valid,
    output logic                  disp_ready,
    input  intm_pkg::intm_uop_t   disp_uop,
    cdb_itf.snoop                 cdb [`INTM_CDB_WIDTH],
    rs_prf_itf.rs                 prf,
    output logic                  issue_valid,
    input  logic                  issue_ready,
    output intm_pkg::intm_issue_t issue
);

    typedef logic [`INTM_RS_IDX-1:0] rs_idx_t;

    // lane tags only, values come through the regfile bypass
    logic                     lane_valid [`INTM_CDB_WIDTH];
    logic [`INTM_PRF_IDX-1:0] lane_tag   [`INTM_CDB_WIDTH];

    for (genvar k = 0; k < `INTM_CDB_WIDTH; k++) begin : g_lane
        assign lane_valid[k] = cdb[k].valid;
        assign lane_tag[k]   = cdb[k].rd_phy;
    end

    // entry storage and free bits
    intm_pkg::intm_uop_t       entry [`INTM_RS_DEPTH];
    logic [`INTM_RS_DEPTH-1:0] free_q;

    logic    push_en;
    rs_idx_t push_idx;
    logic    issue_fire;
    rs_idx_t issue_idx;

    // any lane broadcasting this tag now
    function automatic logic tag_hit(input logic [`INTM_PRF_IDX-1:0] tag);
        logic hit;
        hit = 1'b0;
        for (int k = 0; k < `INTM_CDB_WIDTH; k++) begin
            if (lane_valid[k] && lane_tag[k] == tag) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    // --------------------------------------------------
    // allocation
    // --------------------------------------------------
    assign disp_ready = |free_q;
    assign push_en    = disp_valid && disp_ready;

    // walk down so the lowest free entry wins
    always_comb begin
        push_idx = '0;
        for (int i = `INTM_RS_DEPTH - 1; i >= 0; i--) begin
            if (free_q[i]) begin
                push_idx = rs_idx_t'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            free_q <= '1;
        end else begin
            if (push_en) begin
                free_q[push_idx] <= 1'b0;
            end
            // issue never picks the entry being pushed
            if (issue_fire) begin
                free_q[issue_idx] <= 1'b1;
            end
        end
    end

    // --------------------------------------------------
    // entry payload and wakeup
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        for (int i = 0; i < `INTM_RS_DEPTH; i++) begin
            if (!free_q[i]) begin
                if (tag_hit(entry[i].rs1_phy)) begin
                    entry[i].rs1_valid <= 1'b1;
                end
                if (tag_hit(entry[i].rs2_phy)) begin
                    entry[i].rs2_valid <= 1'b1;
                end
            end
        end
        if (push_en) begin
            entry[push_idx] <= disp_uop;
            // catch a broadcast landing on the dispatch edge
            entry[push_idx].rs1_valid <= disp_uop.rs1_valid || tag_hit(disp_uop.rs1_phy);
            entry[push_idx].rs2_valid <= disp_uop.rs2_valid || tag_hit(disp_uop.rs2_phy);
        end
    end

    // --------------------------------------------------
    // issue select
    // --------------------------------------------------
    // highest ready entry wins, wakeup counts this cycle
    always_comb begin
        issue_valid = 1'b0;
        issue_idx   = '0;
        for (int i = 0; i < `INTM_RS_DEPTH; i++) begin
            if (!free_q[i]
                && (entry[i].rs1_valid || tag_hit(entry[i].rs1_phy))
                && (entry[i].rs2_valid || tag_hit(entry[i].rs2_phy))) begin
                issue_valid = 1'b1;
                issue_idx   = rs_idx_t'(i);
            end
        end
    end

    assign issue_fire = issue_valid && issue_ready;

    // operand read for the selected entry
    assign prf.rs1_phy = entry[issue_idx].rs1_phy;
    assign prf.rs2_phy = entry[issue_idx].rs2_phy;

    assign issue.rob_id    = entry[issue_idx].rob_id;
    assign issue.rd_phy    = entry[issue_idx].rd_phy;
    assign issue.op        = entry[issue_idx].op;
    assign issue.rs1_value = prf.rs1_value;
    assign issue.rs2_value = prf.rs2_value;

endmodule

// ==== hw/md_ctrl.sv ====
`timescale 1ns/1ps

module md_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic issue_valid,
    output logic issue_ready,
    input  logic last_step,
    output logic load,
    output logic step,
    output logic done
);

    intm_pkg::md_state_e state_q;
    intm_pkg::md_state_e state_d;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= intm_pkg::MD_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // --------------------------------------------------
    // next state
    // --------------------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            // wait for an issue transfer
            intm_pkg::MD_IDLE: begin
                if (issue_valid) begin
                    state_d = intm_pkg::MD_BUSY;
                end
            end
            // one iteration per cycle
            intm_pkg::MD_BUSY: begin
                if (last_step) begin
                    state_d = intm_pkg::MD_DONE;
                end
            end
            // single broadcast cycle
            intm_pkg::MD_DONE: begin
                state_d = intm_pkg::MD_IDLE;
            end
            default: begin
                state_d = intm_pkg::MD_IDLE;
            end
        endcase
    end

    // one op in flight, accept only when idle
    assign issue_ready = (state_q == intm_pkg::MD_IDLE);
    assign load        = issue_ready && issue_valid;
    assign step        = (state_q == intm_pkg::MD_BUSY);
    // lane 0 valid
    assign done        = (state_q == intm_pkg::MD_DONE);

endmodule

// ==== hw/md_iter_counter.sv ====
`timescale 1ns/1ps
`include "intm_settings.svh"

module md_iter_counter (
    input  logic clk,
    input  logic rst,
    input  logic load,
    input  logic step,
    output logic last_step
);

    // remaining iterations minus one
    logic [$clog2(`INTM_XLEN)-1:0] count;

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (load) begin
            count <= ($clog2(`INTM_XLEN))'(`INTM_XLEN - 1);
        end else if (step) begin
            count <= count - 1'b1;
        end
    end

    // final iteration happening this cycle
    assign last_step = step && (count == '0);

endmodule

// ==== hw/md_datapath.sv ====
`timescale 1ns/1ps
`include "intm_settings.svh"

module md_datapath (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  load,
    input  logic                  step,
    input  intm_pkg::intm_issue_t issue,
    cdb_itf.src                   cdb
);

    // captured operands
    // mul: src_a multiplicand, src_b multiplier shifts right
    // div: src_a dividend shifts left, src_b divisor
    logic [`INTM_XLEN-1:0]    src_a;
    logic [`INTM_XLEN-1:0]    src_b;
    intm_pkg::md_op_e         op_q;
    logic [`INTM_ROB_IDX-1:0] rob_id_q;
    logic [`INTM_PRF_IDX-1:0] rd_phy_q;

    // hi half = partial product or remainder
    // lo half = product low bits or quotient
    logic [2*`INTM_XLEN-1:0]  acc;

    logic                     is_div;
    logic [`INTM_XLEN:0]      mul_sum;
    logic [`INTM_XLEN:0]      rem_shift;
    logic [`INTM_XLEN:0]      rem_diff;
    logic                     q_bit;
    logic [`INTM_XLEN-1:0]    rem_next;

    assign is_div = (op_q == intm_pkg::MD_DIVU) || (op_q == intm_pkg::MD_REMU);

    // --------------------------------------------------
    // one iteration of each algorithm
    // --------------------------------------------------
    // shift-add, carry kept in bit XLEN
    assign mul_sum = {1'b0, acc[2*`INTM_XLEN-1:`INTM_XLEN]}
                   + (src_b[0] ? {1'b0, src_a} : '0);

    // restoring divide, bring in next dividend bit
    assign rem_shift = {acc[2*`INTM_XLEN-1:`INTM_XLEN], src_a[`INTM_XLEN-1]};
    assign rem_diff  = rem_shift - {1'b0, src_b};
    // divisor zero always subtracts, giving all-ones quotient
    assign q_bit     = (rem_shift >= {1'b0, src_b});
    assign rem_next  = q_bit ? rem_diff[`INTM_XLEN-1:0] : rem_shift[`INTM_XLEN-1:0];

    // operands and tags
    always_ff @(posedge clk) begin
        if (load) begin
            src_a    <= issue.rs1_value;
            src_b    <= issue.rs2_value;
            op_q     <= issue.op;
            rob_id_q <= issue.rob_id;
            rd_phy_q <= issue.rd_phy;
        end else if (step) begin
            if (is_div) begin
                src_a <= src_a << 1;
            end else begin
                src_b <= src_b >> 1;
            end
        end
    end

    // accumulator
    always_ff @(posedge clk) begin
        if (rst || load) begin
            acc <= '0;
        end else if (step) begin
            if (is_div) begin
                acc <= {rem_next, acc[`INTM_XLEN-2:0], q_bit};
            end else begin
                acc <= {mul_sum, acc[`INTM_XLEN-1:1]};
            end
        end
    end

    // --------------------------------------------------
    // lane 0 payload, valid comes from control
    // --------------------------------------------------
    always_comb begin
        case (op_q)
            intm_pkg::MD_MULHU,
            intm_pkg::MD_REMU: cdb.value = acc[2*`INTM_XLEN-1:`INTM_XLEN];
            default:           cdb.value = acc[`INTM_XLEN-1:0];
        endcase
    end

    assign cdb.rob_id = rob_id_q;
    assign cdb.rd_phy = rd_phy_q;

endmodule

// ==== hw/intm_top.sv ====
`timescale 1ns/1ps
`include "intm_settings.svh"

module intm_top (
    input  logic                     clk,
    input  logic                     rst,
    // dispatch
    input  logic                     disp_valid,
    output logic                     disp_ready,
    input  logic [`INTM_ROB_IDX-1:0] disp_rob_id,
    input  logic [`INTM_PRF_IDX-1:0] disp_rd_phy,
    input  logic [`INTM_PRF_IDX-1:0] disp_rs1_phy,
    input  logic                     disp_rs1_valid,
    input  logic [`INTM_PRF_IDX-1:0] disp_rs2_phy,
    input  logic                     disp_rs2_valid,
    input  intm_pkg::md_op_e         disp_op,
    // writeback from other units
    input  logic                     ext_wb_valid,
    input  logic [`INTM_PRF_IDX-1:0] ext_wb_rd_phy,
    input  logic [`INTM_XLEN-1:0]    ext_wb_value,
    // lane 0 out
    output logic                     cdb_valid,
    output logic [`INTM_ROB_IDX-1:0] cdb_rob_id,
    output logic [`INTM_PRF_IDX-1:0] cdb_rd_phy,
    output logic [`INTM_XLEN-1:0]    cdb_value
);

    cdb_itf    cdb_lane [`INTM_CDB_WIDTH] ();
    rs_prf_itf rs_prf ();

    intm_pkg::intm_uop_t   disp_uop;
    intm_pkg::intm_issue_t issue;
    logic                  issue_valid;
    logic                  issue_ready;
    logic                  load;
    logic                  step;
    logic                  last_step;
    logic                  md_done;

    assign disp_uop = '{
        rob_id:    disp_rob_id,
        rd_phy:    disp_rd_phy,
        rs1_phy:   disp_rs1_phy,
        rs2_phy:   disp_rs2_phy,
        rs1_valid: disp_rs1_valid,
        rs2_valid: disp_rs2_valid,
        op:        disp_op
    };

    // external lane, no rob id from outside
    assign cdb_lane[1].valid  = ext_wb_valid;
    assign cdb_lane[1].rob_id = '0;
    assign cdb_lane[1].rd_phy = ext_wb_rd_phy;
    assign cdb_lane[1].value  = ext_wb_value;

    assign cdb_lane[0].valid = md_done;

    assign cdb_valid  = cdb_lane[0].valid;
    assign cdb_rob_id = cdb_lane[0].rob_id;
    assign cdb_rd_phy = cdb_lane[0].rd_phy;
    assign cdb_value  = cdb_lane[0].value;

    phys_regfile phys_regfile_inst (
        .clk (clk),
        .rst (rst),
        .cdb (cdb_lane),
        .prf (rs_prf)
    );

    intm_rs intm_rs_inst (
        .clk         (clk),
        .rst         (rst),
        .disp_valid  (disp_valid),
        .disp_ready  (disp_ready),
        .disp_uop    (disp_uop),
        .cdb         (cdb_lane),
        .prf         (rs_prf),
        .issue_valid (issue_valid),
        .issue_ready (issue_ready),
        .issue       (issue)
    );

    md_ctrl md_ctrl_inst (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue_ready (issue_ready),
        .last_step   (last_step),
        .load        (load),
        .step        (step),
        .done        (md_done)
    );

    md_iter_counter md_iter_counter_inst (
        .clk       (clk),
        .rst       (rst),
        .load      (load),
        .step      (step),
        .last_step (last_step)
    );

    md_datapath md_datapath_inst (
        .clk   (clk),
        .rst   (rst),
        .load  (load),
        .step  (step),
        .issue (issue),
        .cdb   (cdb_lane[0])
    );

endmodule

// ==== sim/intm_tb.sv ====
`timescale 1ns/1ps
`include "intm_settings.svh"

module intm_tb;

    localparam int WAIT_LIMIT = 400;
    localparam int RAND_ROWS  = 40;

    logic                     clk;
    logic                     rst;
    logic                     disp_valid;
    logic                     disp_ready;
    logic [`INTM_ROB_IDX-1:0] disp_rob_id;
    logic [`INTM_PRF_IDX-1:0] disp_rd_phy;
    logic [`INTM_PRF_IDX-1:0] disp_rs1_phy;
    logic                     disp_rs1_valid;
    logic [`INTM_PRF_IDX-1:0] disp_rs2_phy;
    logic                     disp_rs2_valid;
    intm_pkg::md_op_e         disp_op;
    logic                     ext_wb_valid;
    logic [`INTM_PRF_IDX-1:0] ext_wb_rd_phy;
    logic [`INTM_XLEN-1:0]    ext_wb_value;
    logic                     cdb_valid;
    logic [`INTM_ROB_IDX-1:0] cdb_rob_id;
    logic [`INTM_PRF_IDX-1:0] cdb_rd_phy;
    logic [`INTM_XLEN-1:0]    cdb_value;

    int     err_count;
    int     timeout_count;
    integer seed;

    // outstanding results, indexed by rob id
    logic [(1<<`INTM_ROB_IDX)-1:0] pending;
    logic [`INTM_XLEN-1:0]         exp_value [1<<`INTM_ROB_IDX];
    logic [`INTM_PRF_IDX-1:0]      exp_rd    [1<<`INTM_ROB_IDX];

    // stimulus table: op, a, b, expected
    intm_pkg::md_op_e      op_tab  [$];
    logic [`INTM_XLEN-1:0] a_tab   [$];
    logic [`INTM_XLEN-1:0] b_tab   [$];
    logic [`INTM_XLEN-1:0] exp_tab [$];

    intm_top intm_top_inst (
        .clk            (clk),
        .rst            (rst),
        .disp_valid     (disp_valid),
        .disp_ready     (disp_ready),
        .disp_rob_id    (disp_rob_id),
        .disp_rd_phy    (disp_rd_phy),
        .disp_rs1_phy   (disp_rs1_phy),
        .disp_rs1_valid (disp_rs1_valid),
        .disp_rs2_phy   (disp_rs2_phy),
        .disp_rs2_valid (disp_rs2_valid),
        .disp_op        (disp_op),
        .ext_wb_valid   (ext_wb_valid),
        .ext_wb_rd_phy  (ext_wb_rd_phy),
        .ext_wb_value   (ext_wb_value),
        .cdb_valid      (cdb_valid),
        .cdb_rob_id     (cdb_rob_id),
        .cdb_rd_phy     (cdb_rd_phy),
        .cdb_value      (cdb_value)
    );

    // 4 ns period
    always #2 clk = ~clk;

    // --------------------------------------------------
    // reference model, unsigned ops
    // --------------------------------------------------
    function automatic logic [`INTM_XLEN-1:0] expected_result(
        input intm_pkg::md_op_e      op,
        input logic [`INTM_XLEN-1:0] a,
        input logic [`INTM_XLEN-1:0] b
    );
        logic [2*`INTM_XLEN-1:0] prod;
        prod = {{`INTM_XLEN{1'b0}}, a} * {{`INTM_XLEN{1'b0}}, b};
        case (op)
            intm_pkg::MD_MUL:   return prod[`INTM_XLEN-1:0];
            intm_pkg::MD_MULHU: return prod[2*`INTM_XLEN-1:`INTM_XLEN];
            // divide by zero: all ones / dividend
            intm_pkg::MD_DIVU:  return (b == 0) ? '1 : a / b;
            default:            return (b == 0) ? a : a % b;
        endcase
    endfunction

    // --------------------------------------------------
    // lane 0 monitor, results in any order
    // --------------------------------------------------
    always @(negedge clk) begin
        if (!rst && cdb_valid) begin
            assert (pending[cdb_rob_id])
            else begin
                $display("Fail %0t: result for rob %0d not expected", $time, cdb_rob_id);
                err_count++;
            end
            assert (cdb_value == exp_value[cdb_rob_id])
            else begin
                $display("Fail %0t: rob %0d value %h, expected %h", $time, cdb_rob_id,
                         cdb_value, exp_value[cdb_rob_id]);
                err_count++;
            end
            assert (cdb_rd_phy == exp_rd[cdb_rob_id])
            else begin
                $display("Fail %0t: rob %0d rd_phy %0d, expected %0d", $time, cdb_rob_id,
                         cdb_rd_phy, exp_rd[cdb_rob_id]);
                err_count++;
            end
            pending[cdb_rob_id] = 1'b0;
        end
    end

    task automatic add_row(input intm_pkg::md_op_e op, input logic [`INTM_XLEN-1:0] a,
                           input logic [`INTM_XLEN-1:0] b, input logic [`INTM_XLEN-1:0] e);
        op_tab.push_back(op);
        a_tab.push_back(a);
        b_tab.push_back(b);
        exp_tab.push_back(e);
    endtask

    // one write on the external lane
    task automatic write_reg(input logic [`INTM_PRF_IDX-1:0] tag,
                             input logic [`INTM_XLEN-1:0] value);
        @(negedge clk);
        ext_wb_valid  = 1'b1;
        ext_wb_rd_phy = tag;
        ext_wb_value  = value;
        @(negedge clk);
        ext_wb_valid  = 1'b0;
    endtask

    task automatic expect_result(input logic [`INTM_ROB_IDX-1:0] rob,
                                 input logic [`INTM_PRF_IDX-1:0] rd,
                                 input logic [`INTM_XLEN-1:0] value);
        exp_value[rob] = value;
        exp_rd[rob]    = rd;
        pending[rob]   = 1'b1;
    endtask

    task automatic dispatch(input logic [`INTM_ROB_IDX-1:0] rob,
                            input logic [`INTM_PRF_IDX-1:0] rd, input intm_pkg::md_op_e op,
                            input logic [`INTM_PRF_IDX-1:0] rs1, input logic v1,
                            input logic [`INTM_PRF_IDX-1:0] rs2, input logic v2);
        int t;
        t = 0;
        @(negedge clk);
        while (!disp_ready && t < WAIT_LIMIT) begin
            @(negedge clk);
            t++;
        end
        if (!disp_ready) begin
            $display("Timeout: station never accepted rob %0d", rob);
            timeout_count++;
        end else begin
            disp_valid     = 1'b1;
            disp_rob_id    = rob;
            disp_rd_phy    = rd;
            disp_op        = op;
            disp_rs1_phy   = rs1;
            disp_rs1_valid = v1;
            disp_rs2_phy   = rs2;
            disp_rs2_valid = v2;
            @(negedge clk);
            disp_valid     = 1'b0;
        end
    endtask

    // until every expected result has come back
    task automatic wait_results();
        int t;
        t = 0;
        while (pending != 0 && t < WAIT_LIMIT) begin
            @(posedge clk);
            t++;
        end
        if (pending != 0) begin
            $display("Timeout: results still missing, pending mask %h", pending);
            timeout_count++;
            pending = '0;
        end
    endtask

    initial begin
        logic [`INTM_ROB_IDX-1:0] rob;
        logic [`INTM_XLEN-1:0]    ra;
        logic [`INTM_XLEN-1:0]    rb;
        intm_pkg::md_op_e         rop;

        clk            = 1'b0;
        rst            = 1'b1;
        disp_valid     = 1'b0;
        disp_rob_id    = '0;
        disp_rd_phy    = '0;
        disp_rs1_phy   = '0;
        disp_rs1_valid = 1'b0;
        disp_rs2_phy   = '0;
        disp_rs2_valid = 1'b0;
        disp_op        = intm_pkg::MD_MUL;
        ext_wb_valid   = 1'b0;
        ext_wb_rd_phy  = '0;
        ext_wb_value   = '0;
        err_count      = 0;
        timeout_count  = 0;
        pending        = '0;
        seed           = 20;

        repeat (3) @(negedge clk);
        rst = 1'b0;

        // --------------------------------------------------
        // idle after reset
        // --------------------------------------------------
        repeat (5) begin
            @(negedge clk);
            assert (disp_ready && !cdb_valid)
            else begin
                $display("Fail %0t: idle state wrong after reset", $time);
                err_count++;
            end
        end

        // --------------------------------------------------
        // table rows, fixed then random
        // --------------------------------------------------
        add_row(intm_pkg::MD_MUL,   32'd7,         32'd6,         32'h0000002a);
        add_row(intm_pkg::MD_MUL,   32'hffffffff,  32'hffffffff,  32'h00000001);
        add_row(intm_pkg::MD_MULHU, 32'hffffffff,  32'hffffffff,  32'hfffffffe);
        add_row(intm_pkg::MD_MUL,   32'h80000000,  32'd4,         32'h00000000);
        add_row(intm_pkg::MD_MULHU, 32'h80000000,  32'd4,         32'h00000002);
        add_row(intm_pkg::MD_MULHU, 32'h00010000,  32'h00010000,  32'h00000001);
        add_row(intm_pkg::MD_DIVU,  32'd100,       32'd7,         32'h0000000e);
        add_row(intm_pkg::MD_REMU,  32'd100,       32'd7,         32'h00000002);
        add_row(intm_pkg::MD_DIVU,  32'd5,         32'd0,         32'hffffffff);
        add_row(intm_pkg::MD_REMU,  32'd5,         32'd0,         32'h00000005);
        add_row(intm_pkg::MD_DIVU,  32'hffffffff,  32'd1,         32'hffffffff);
        add_row(intm_pkg::MD_REMU,  32'hffffffff,  32'hffffffff,  32'h00000000);
        add_row(intm_pkg::MD_DIVU,  32'd3,         32'hffffffff,  32'h00000000);
        add_row(intm_pkg::MD_REMU,  32'd3,         32'hffffffff,  32'h00000003);
        for (int i = 0; i < RAND_ROWS; i++) begin
            rop = intm_pkg::md_op_e'($random(seed) & 3);
            ra  = $random(seed);
            rb  = $random(seed);
            // small divisors now and then, zero included
            if (($random(seed) & 3) == 0) begin
                rb = rb >> 29;
            end
            add_row(rop, ra, rb, expected_result(rop, ra, rb));
        end

        for (int i = 0; i < op_tab.size(); i++) begin
            rob = `INTM_ROB_IDX'(i);
            write_reg(5'd1, a_tab[i]);
            write_reg(5'd2, b_tab[i]);
            expect_result(rob, 5'd3, exp_tab[i]);
            dispatch(rob, 5'd3, op_tab[i], 5'd1, 1'b1, 5'd2, 1'b1);
            wait_results();
        end

        // --------------------------------------------------
        // wakeup from the external lane
        // --------------------------------------------------
        write_reg(5'd1, 32'd1000);
        expect_result(4'd9, 5'd5, expected_result(intm_pkg::MD_REMU, 32'd1000, 32'd37));
        dispatch(4'd9, 5'd5, intm_pkg::MD_REMU, 5'd1, 1'b1, 5'd4, 1'b0);
        // window longer than one full op latency
        repeat (`INTM_XLEN + 8) begin
            @(negedge clk);
            assert (!(cdb_valid && cdb_rob_id == 4'd9))
            else begin
                $display("Fail %0t: rob 9 issued before its source was written", $time);
                err_count++;
            end
        end
        write_reg(5'd4, 32'd37);
        wait_results();

        // --------------------------------------------------
        // fill the station, then release
        // --------------------------------------------------
        for (int k = 0; k < 4; k++) begin
            rop = intm_pkg::md_op_e'(k);
            expect_result(`INTM_ROB_IDX'(10 + k), `INTM_PRF_IDX'(24 + k),
                          expected_result(rop, 1000 + k * 37, k + 3));
            dispatch(`INTM_ROB_IDX'(10 + k), `INTM_PRF_IDX'(24 + k), rop,
                     `INTM_PRF_IDX'(16 + 2 * k), 1'b0, `INTM_PRF_IDX'(17 + 2 * k), 1'b0);
        end
        assert (!disp_ready)
        else begin
            $display("Fail %0t: disp_ready high with a full station", $time);
            err_count++;
        end
        for (int k = 0; k < 4; k++) begin
            write_reg(`INTM_PRF_IDX'(16 + 2 * k), 1000 + k * 37);
            write_reg(`INTM_PRF_IDX'(17 + 2 * k), k + 3);
        end
        wait_results();
        @(negedge clk);
        assert (disp_ready)
        else begin
            $display("Fail %0t: disp_ready low after the station drained", $time);
            err_count++;
        end

        // --------------------------------------------------
        // chained through the lane 0 broadcast
        // --------------------------------------------------
        write_reg(5'd1, 32'd13);
        write_reg(5'd2, 32'd11);
        ra = expected_result(intm_pkg::MD_MUL, 32'd13, 32'd11);
        expect_result(4'd1, 5'd6, ra);
        expect_result(4'd2, 5'd7, expected_result(intm_pkg::MD_DIVU, ra, 32'd11));
        dispatch(4'd1, 5'd6, intm_pkg::MD_MUL, 5'd1, 1'b1, 5'd2, 1'b1);
        dispatch(4'd2, 5'd7, intm_pkg::MD_DIVU, 5'd6, 1'b0, 5'd2, 1'b1);
        wait_results();

        repeat (3) @(negedge clk);
        $display("errors: %0d, timeouts: %0d", err_count, timeout_count);
        if (err_count == 0 && timeout_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+include
hw/intm_pkg.sv
hw/intm_itf.sv
hw/phys_regfile.sv
hw/intm_rs.sv
hw/md_ctrl.sv
hw/md_iter_counter.sv
hw/md_datapath.sv
hw/intm_top.sv
sim/intm_tb.sv
